/* Makefile */
TOP = tb_pwm_top

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

/* bench/pwm_props.sv */
`timescale 1ns/10ps
`default_nettype none

module pwm_props
	import pwm_pkg::*;
	import wb_pkg::*;
(
	input wire logic     clk_i,
	input wire logic     rst_i,
	input wire wb_req_t  wb_req_i,
	input wire wb_rsp_t  wb_rsp_i,
	input wire pwm_cfg_t cfg_i,
	input wire logic     pwm_i
);

	// Single-cycle ack.
	ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
		else $error("ack high for two cycles in a row");

	ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_i)
		wb_rsp_i.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
		else $error("ack without a preceding cyc and stb");

	// Active settings, not the host registers.
	off_low: assert property (@(posedge clk_i) disable iff (!rst_i)
		(cfg_i.mode == MODE_OFF) |-> !pwm_i)
		else $error("pwm_o high while the active mode is off");

endmodule

bind pwm_top pwm_props u_props (
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.wb_req_i (wb_req_i),
	.wb_rsp_i (wb_rsp_o),
	.cfg_i    (cfg_active),
	.pwm_i    (pwm_o)
);

`default_nettype wire

/* bench/tb_pwm_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_pwm_top
	import pwm_pkg::*;
	import wb_pkg::*;
();

	// Cycle budgets that size the watchdog.
	localparam int OFF_CYC    = 300;
	localparam int REGS_CYC   = 100;
	localparam int STD_CYC    = 2400;
	localparam int HEART_CYC  = 400;
	localparam int SHADOW_CYC = 400;
	localparam int SWITCH_CYC = 500;
	localparam int MARGIN_CYC = 600;
	localparam int WATCH_CYC  = OFF_CYC + REGS_CYC + STD_CYC + HEART_CYC + SHADOW_CYC
		+ SWITCH_CYC + MARGIN_CYC;

	localparam wb_data_t MODE_MASK = (1 << MODE_W) - 1;
	localparam wb_data_t STEP_MASK = (1 << STEP_W) - 1;

	typedef struct packed {
		count_t cnt;
		count_t hthr;
		logic   reload;
		logic   pwm;
	} chan_st_t;

	logic     clk_i;
	logic     rst_i;
	wb_req_t  wb_req;
	wb_rsp_t  wb_rsp;
	logic     pwm_o;

	chan_st_t m_st;   // Model generator state.
	pwm_cfg_t m_host; // Model register file.
	pwm_cfg_t m_act;  // Model active settings.
	logic     m_pend;
	int       wr_seq = 0;
	int       wr_seen = 0;
	wb_addr_t wr_adr;
	wb_data_t wr_dat;
	int       data_errs = 0;
	int       pwm_errs = 0;
	int       tests = 0;

	pwm_top u_pwm_top (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp),
		.pwm_o    (pwm_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// Next generator state from the active settings.
	function automatic chan_st_t pwm_step(chan_st_t s, pwm_cfg_t c);
		chan_st_t n;
		logic     last;
		n     = s;
		n.pwm = 1'b0;
		last  = (s.cnt == c.period - 32'd1);
		if (c.mode == MODE_STD) begin
			n.reload = 1'b1;
			if (last) begin
				n.cnt = '0;
			end else begin
				n.cnt = s.cnt + 32'd1;
				n.pwm = (s.cnt < c.thr1);
			end
		end else if (c.mode == MODE_HEART) begin
			if (s.reload) begin
				n.hthr   = c.thr1;
				n.reload = 1'b0;
			end else if (s.hthr > c.thr2) begin
				n.cnt  = '0; // Ramp restarts.
				n.hthr = c.thr1;
			end else if (last) begin
				n.cnt  = '0;
				n.hthr = s.hthr + count_t'(c.step);
			end else begin
				n.cnt = s.cnt + 32'd1;
				n.pwm = (s.cnt < s.hthr);
			end
		end else begin
			n.reload = 1'b1;
		end
		return n;
	endfunction

	function automatic pwm_cfg_t host_write(pwm_cfg_t h, wb_addr_t adr, wb_data_t dat);
		pwm_cfg_t n;
		n = h;
		case (adr)
			REG_MODE:   n.mode   = pwm_mode_t'(dat[MODE_W-1:0]);
			REG_PERIOD: n.period = dat;
			REG_THR1:   n.thr1   = dat;
			REG_THR2:   n.thr2   = dat;
			REG_STEP:   n.step   = dat[STEP_W-1:0];
			default:    n = h;
		endcase
		return n;
	endfunction

	task automatic check_data(wb_data_t got, wb_data_t exp, string what);
		if (got !== exp) begin
			data_errs++;
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(logic got, logic exp);
		if (got !== exp) begin
			pwm_errs++;
			$display("mismatch at %0t ns: pwm_o is %b, model has %b", $time, got, exp);
		end
	endtask

	// Model of register file, shadow stage and generator.
	initial begin : model
		chan_st_t nxt;
		logic     swap;
		forever begin
			@(posedge clk_i);
			if (!rst_i) begin
				m_st   = '0;
				m_host = '0;
				m_act  = '0;
				m_pend = 1'b0;
			end else begin
				swap = m_pend && ((m_st.cnt == m_act.period - 32'd1)
					|| !(m_act.mode == MODE_STD || m_act.mode == MODE_HEART));
				nxt = pwm_step(m_st, m_act);
				if (swap) m_act = m_host; // Old host value.
				if (wr_seq != wr_seen) begin
					m_host  = host_write(m_host, wr_adr, wr_dat);
					m_pend  = 1'b1;
					wr_seen = wr_seq;
				end else if (swap) begin
					m_pend = 1'b0;
				end
				m_st = nxt;
			end
			@(negedge clk_i);
			if (rst_i) check_bit(pwm_o, m_st.pwm);
		end
	end

	task automatic wait_ack(output wb_data_t dat);
		int n;
		n = 0;
		do begin
			@(negedge clk_i);
			n++;
		end while (!wb_rsp.ack && n < 8);
		if (!wb_rsp.ack) begin
			data_errs++;
			$display("bus error at %0t ns: no ack within 8 cycles", $time);
		end else if (n != 2) begin
			data_errs++;
			$display("bus error at %0t ns: ack after %0d cycles instead of 2", $time, n);
		end
		dat = wb_rsp.dat;
	endtask

	task automatic wb_write(wb_addr_t adr, wb_data_t dat);
		wb_data_t unused;
		@(posedge clk_i);
		#5;
		wb_req = '{1'b1, 1'b1, 1'b1, adr, dat};
		wait_ack(unused);
		wr_adr = adr; // Lands in the model at the next edge.
		wr_dat = dat;
		wr_seq++;
		@(posedge clk_i);
		#5;
		wb_req = '0;
	endtask

	task automatic wb_read(wb_addr_t adr, output wb_data_t dat);
		@(posedge clk_i);
		#5;
		wb_req = '{1'b1, 1'b1, 1'b0, adr, '0};
		wait_ack(dat);
		@(posedge clk_i);
		#5;
		wb_req = '0;
	endtask

	task automatic wait_cycles(int n);
		repeat (n) @(negedge clk_i);
	endtask

	// Stops where the model counter has just wrapped.
	task automatic wait_period_start();
		do @(negedge clk_i); while (m_st.cnt != 0);
	endtask

	task automatic count_high(int n, output int highs);
		highs = 0;
		repeat (n) begin
			@(negedge clk_i);
			if (pwm_o) highs++;
		end
	endtask

	task automatic set_std(wb_data_t period, wb_data_t thr);
		wb_write(REG_PERIOD, period);
		wb_write(REG_THR1, thr);
		wb_write(REG_MODE, wb_data_t'(MODE_STD));
	endtask

	task automatic end_test(string name, int errs_at_start);
		int errs;
		errs = data_errs + pwm_errs - errs_at_start;
		tests++;
		$display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
	endtask

	task automatic off_mode();
		int e0;
		int highs;
		e0 = data_errs + pwm_errs;
		count_high(20, highs);
		check_data(highs, 0, "high cycles after reset");
		set_std(8, 3);
		wait_cycles(40);
		count_high(16, highs);
		check_data(highs, 6, "high cycles in standard");
		wb_write(REG_MODE, wb_data_t'(MODE_OFF));
		wait_cycles(20);
		count_high(30, highs);
		check_data(highs, 0, "high cycles in off");
		wb_write(REG_MODE, wb_data_t'(MODE_RSVD));
		wait_cycles(20);
		count_high(30, highs);
		check_data(highs, 0, "high cycles in reserved");
		end_test("off mode", e0);
	endtask

	task automatic register_readback();
		int       e0;
		wb_data_t val [5];
		wb_data_t exp;
		wb_data_t got;
		e0 = data_errs + pwm_errs;
		for (int i = 0; i < 5; i++) begin
			val[i] = $urandom();
		end
		val[0][1:0] = {2{val[0][0]}}; // Off or reserved only.
		for (int i = 0; i < 5; i++) begin
			wb_write(wb_addr_t'(i), val[i]);
		end
		// Unmapped writes must leave the settings alone.
		for (int a = 5; a < 8; a++) begin
			wb_write(wb_addr_t'(a), $urandom());
		end
		for (int i = 0; i < 5; i++) begin
			wb_read(wb_addr_t'(i), got);
			exp = (i == 0) ? (val[i] & MODE_MASK) : (i == 4) ? (val[i] & STEP_MASK) : val[i];
			check_data(got, exp, "register readback");
		end
		for (int a = 5; a < 8; a++) begin
			wb_read(wb_addr_t'(a), got);
			check_data(got, '0, "unmapped readback");
		end
		end_test("readback", e0);
	endtask

	task automatic standard_duty();
		int e0;
		int p;
		int t;
		int highs;
		e0 = data_errs + pwm_errs;
		for (int k = 0; k < 6; k++) begin
			p = 4 + $urandom() % 45;
			t = $urandom() % (p + 3);
			set_std(p, t);
			wait_cycles(150);
			count_high(4 * p, highs);
			check_data(highs, 4 * ((t < p - 1) ? t : p - 1), "high cycles in 4 periods");
		end
		end_test("standard", e0);
	endtask

	task automatic heartbeat_ramp();
		int e0;
		int run;
		int prev;
		int pulses;
		e0 = data_errs + pwm_errs;
		wb_write(REG_PERIOD, 10);
		wb_write(REG_THR1, 1);
		wb_write(REG_THR2, 7);
		wb_write(REG_STEP, 2);
		wb_write(REG_MODE, wb_data_t'(MODE_HEART));
		wait_cycles(120);
		do @(negedge clk_i); while (pwm_o);
		run    = 0;
		prev   = 0;
		pulses = 0;
		repeat (160) begin
			@(negedge clk_i);
			if (pwm_o) begin
				run++;
			end else if (run > 0) begin
				if (pulses > 0) check_data(run, (prev + 2 > 7) ? 1 : prev + 2, "pulse width");
				prev = run;
				run  = 0;
				pulses++;
			end
		end
		if (pulses < 8) begin
			data_errs++;
			$display("heartbeat gave only %0d pulses in 160 cycles", pulses);
		end
		end_test("heartbeat", e0);
	endtask

	task automatic shadow_update();
		int e0;
		int highs;
		e0 = data_errs + pwm_errs;
		set_std(20, 5);
		wait_cycles(100);
		wait_period_start();
		fork
			wb_write(REG_THR1, 12);
			count_high(20, highs);
		join
		check_data(highs, 5, "period before thr1 update");
		count_high(20, highs);
		check_data(highs, 12, "period after thr1 update");
		wait_period_start();
		fork
			wb_write(REG_PERIOD, 12);
			count_high(20, highs);
		join
		check_data(highs, 12, "period before period update");
		count_high(12, highs);
		check_data(highs, 11, "period after period update");
		end_test("shadow", e0);
	endtask

	task automatic mode_switch();
		int e0;
		int highs;
		e0 = data_errs + pwm_errs;
		wb_write(REG_PERIOD, 16);
		wb_write(REG_THR1, 2);
		wb_write(REG_THR2, 9);
		wb_write(REG_STEP, 3);
		wb_write(REG_MODE, wb_data_t'(MODE_HEART));
		wait_cycles(150);
		wb_write(REG_MODE, wb_data_t'(MODE_STD));
		wait_cycles(80);
		wb_write(REG_MODE, wb_data_t'(MODE_OFF));
		wait_cycles(40);
		count_high(40, highs);
		check_data(highs, 0, "high cycles after switch to off");
		end_test("mode switch", e0);
	endtask

	initial begin
		#(WATCH_CYC * 100);
		$display("timeout: tests still running after %0d cycles", WATCH_CYC);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h38734f7f));
		rst_i  = 1'b0;
		wb_req = '0;
		repeat (8) @(posedge clk_i);
		#5;
		rst_i = 1'b1;
		off_mode();
		register_readback();
		standard_duty();
		heartbeat_ramp();
		shadow_update();
		mode_switch();
		$display("tests %0d, data errors %0d, pwm errors %0d", tests, data_errs, pwm_errs);
		if (data_errs + pwm_errs == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
source/pwm_pkg.sv
source/wb_pkg.sv
source/pwm_regs.sv
source/pwm_shadow.sv
source/pwm_channel.sv
source/pwm_top.sv
bench/pwm_props.sv
bench/tb_pwm_top.sv

/* source/pwm_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module pwm_channel
	import pwm_pkg::*;
(
	input  wire logic     clk_i,
	input  wire logic     rst_i,
	input  wire pwm_cfg_t cfg_i,
	output logic          period_end_o,
	output logic          pwm_o
);

	count_t cnt_q;
	count_t cnt_d;
	count_t hthr_q;  // Heartbeat on-threshold.
	count_t hthr_d;
	logic   reload_q; // Load thr1 on heartbeat entry.
	logic   reload_d;
	logic   pwm_q;
	logic   pwm_d;
	logic   at_end;
	count_t step_ext;

	assign at_end   = (cnt_q == cfg_i.period - 1'b1);
	assign step_ext = count_t'(cfg_i.step);

	always_comb begin
		cnt_d    = cnt_q;
		hthr_d   = hthr_q;
		reload_d = reload_q;
		pwm_d    = 1'b0;

		case (cfg_i.mode)
			MODE_STD: begin
				reload_d = 1'b1;
				if (at_end) begin
					cnt_d = '0; // Low in the last cycle.
				end else begin
					cnt_d = cnt_q + 1'b1;
					pwm_d = (cnt_q < cfg_i.thr1);
				end
			end

			MODE_HEART: begin
				if (reload_q) begin
					hthr_d   = cfg_i.thr1;
					reload_d = 1'b0;
				end else if (hthr_q > cfg_i.thr2) begin
					// Ramp done, start over.
					cnt_d  = '0;
					hthr_d = cfg_i.thr1;
				end else if (at_end) begin
					cnt_d  = '0;
					hthr_d = hthr_q + step_ext; // Wider pulse next period.
				end else begin
					cnt_d = cnt_q + 1'b1;
					pwm_d = (cnt_q < hthr_q);
				end
			end

			default: begin
				// Off and reserved hold the counter and threshold.
				reload_d = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			cnt_q    <= '0;
			hthr_q   <= '0;
			reload_q <= 1'b0;
			pwm_q    <= 1'b0;
		end else begin
			cnt_q    <= cnt_d;
			hthr_q   <= hthr_d;
			reload_q <= reload_d;
			pwm_q    <= pwm_d;
		end
	end

	assign period_end_o = at_end;
	assign pwm_o        = pwm_q;

endmodule

`default_nettype wire

/* source/pwm_pkg.sv */
`default_nettype none

package pwm_pkg;

	// Field widths of the settings.
	localparam int MODE_W  = 2;
	localparam int COUNT_W = 32;
	localparam int STEP_W  = 12;

	// Generator mode, as written by the host.
	typedef enum logic [MODE_W-1:0] {
		MODE_OFF   = 2'd0,
		MODE_STD   = 2'd1,
		MODE_HEART = 2'd2,
		MODE_RSVD  = 2'd3 // Behaves like off.
	} pwm_mode_t;

	// Period, thresholds and the counter.
	typedef logic [COUNT_W-1:0] count_t;

	// Heartbeat increment per period.
	typedef logic [STEP_W-1:0] step_t;

	// One complete set of channel settings.
	typedef struct packed {
		pwm_mode_t mode;
		count_t    period; // Cycles per period.
		count_t    thr1;   // Duty in standard mode, ramp start in heartbeat.
		count_t    thr2;   // Ramp limit.
		step_t     step;
	} pwm_cfg_t;

endpackage

`default_nettype wire

/* source/pwm_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module pwm_regs
	import pwm_pkg::*;
	import wb_pkg::*;
(
	input  wire logic    clk_i,
	input  wire logic    rst_i,
	input  wire wb_req_t wb_req_i,
	output wb_rsp_t      wb_rsp_o,
	output pwm_cfg_t     cfg_o,
	output logic         cfg_wr_o
);

	logic      req_new; // Open cycle not yet acked.
	logic      ack_q;
	logic      wr_en;
	wb_data_t  rd_data;
	wb_data_t  rd_data_q;

	// Host-visible settings.
	pwm_mode_t mode_q;
	count_t    period_q;
	count_t    thr1_q;
	count_t    thr2_q;
	step_t     step_q;

	assign req_new = wb_req_i.cyc && wb_req_i.stb && !ack_q;

	// Write lands on the ack cycle.
	assign wr_en = ack_q && wb_req_i.cyc && wb_req_i.stb && wb_req_i.we;

	// One wait cycle, then a single ack.
	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_new;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			mode_q   <= MODE_OFF;
			period_q <= '0;
			thr1_q   <= '0;
			thr2_q   <= '0;
			step_q   <= '0;
		end else if (wr_en) begin
			case (wb_req_i.adr)
				REG_MODE:   mode_q   <= pwm_mode_t'(wb_req_i.dat[MODE_W-1:0]);
				REG_PERIOD: period_q <= wb_req_i.dat;
				REG_THR1:   thr1_q   <= wb_req_i.dat;
				REG_THR2:   thr2_q   <= wb_req_i.dat;
				REG_STEP:   step_q   <= wb_req_i.dat[STEP_W-1:0];
				default:    ; // Unmapped, ignored.
			endcase
		end
	end

	// Read mux, narrow fields zero-extended.
	always_comb begin
		rd_data = '0;
		case (wb_req_i.adr)
			REG_MODE:   rd_data[MODE_W-1:0] = mode_q;
			REG_PERIOD: rd_data = period_q;
			REG_THR1:   rd_data = thr1_q;
			REG_THR2:   rd_data = thr2_q;
			REG_STEP:   rd_data[STEP_W-1:0] = step_q;
			default:    rd_data = '0;
		endcase
	end

	// Sampled together with the ack.
	always_ff @(posedge clk_i) begin
		if (req_new) begin
			rd_data_q <= rd_data;
		end
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = rd_data_q;

	assign cfg_o.mode   = mode_q;
	assign cfg_o.period = period_q;
	assign cfg_o.thr1   = thr1_q;
	assign cfg_o.thr2   = thr2_q;
	assign cfg_o.step   = step_q;

	assign cfg_wr_o = wr_en;

endmodule

`default_nettype wire

/* source/pwm_shadow.sv */
`timescale 1ns/10ps
`default_nettype none

module pwm_shadow
	import pwm_pkg::*;
(
	input  wire logic     clk_i,
	input  wire logic     rst_i,
	input  wire pwm_cfg_t cfg_i,
	input  wire logic     cfg_wr_i,
	input  wire logic     period_end_i,
	output pwm_cfg_t      cfg_o
);

	logic     pending_q; // Host settings differ from the active ones.
	logic     active_run;
	logic     swap;
	pwm_cfg_t active_q;

	// Only a running waveform has a period to protect.
	assign active_run = (active_q.mode == MODE_STD) || (active_q.mode == MODE_HEART);

	assign swap = pending_q && (period_end_i || !active_run);

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			active_q <= '0; // Mode off.
		end else if (swap) begin
			active_q <= cfg_i;
		end
	end

	// A write in the swap cycle keeps the flag.
	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			pending_q <= 1'b0;
		end else if (cfg_wr_i) begin
			pending_q <= 1'b1;
		end else if (swap) begin
			pending_q <= 1'b0;
		end
	end

	assign cfg_o = active_q;

endmodule

`default_nettype wire

/* source/pwm_top.sv */
`timescale 1ns/10ps
`default_nettype none

module pwm_top
	import pwm_pkg::*;
	import wb_pkg::*;
(
	input  wire logic    clk_i,
	input  wire logic    rst_i,
	input  wire wb_req_t wb_req_i,
	output wb_rsp_t      wb_rsp_o,
	output logic         pwm_o
);

	pwm_cfg_t cfg_host;   // As written by the host.
	pwm_cfg_t cfg_active; // As used by the generator.
	logic     cfg_wr;
	logic     period_end;

	pwm_regs u_regs (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.wb_req_i (wb_req_i),
		.wb_rsp_o (wb_rsp_o),
		.cfg_o    (cfg_host),
		.cfg_wr_o (cfg_wr)
	);

	pwm_shadow u_shadow (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cfg_i        (cfg_host),
		.cfg_wr_i     (cfg_wr),
		.period_end_i (period_end),
		.cfg_o        (cfg_active)
	);

	pwm_channel u_channel (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cfg_i        (cfg_active),
		.period_end_o (period_end),
		.pwm_o        (pwm_o)
	);

endmodule

`default_nettype wire

/* source/wb_pkg.sv */
`default_nettype none

package wb_pkg;

	localparam int WB_ADDR_W = 3;
	localparam int WB_DATA_W = 32;

	// Word address and data.
	typedef logic [WB_ADDR_W-1:0] wb_addr_t;
	typedef logic [WB_DATA_W-1:0] wb_data_t;

	// Host to slave.
	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		wb_data_t dat;
	} wb_req_t;

	// Slave to host.
	typedef struct packed {
		logic     ack;
		wb_data_t dat;
	} wb_rsp_t;

	// Register map, word offsets.
	localparam wb_addr_t REG_MODE   = 3'd0;
	localparam wb_addr_t REG_PERIOD = 3'd1;
	localparam wb_addr_t REG_THR1   = 3'd2;
	localparam wb_addr_t REG_THR2   = 3'd3;
	localparam wb_addr_t REG_STEP   = 3'd4;

endpackage

`default_nettype wire
